//--- common/microControlPkg.sv
package microControlPkg;

    // default widths, passed down from the top level
    localparam int StateWidthDefault = 7;
    localparam int WordWidthDefault  = 45;

    localparam int opcodeWidth   = 4;
    localparam int flagWidth     = 3;
    localparam int seqOpWidth    = 3;
    localparam int condSelWidth  = 3;
    localparam int controlsWidth = 32;

    // control word field positions (lsb of each field)
    localparam int seqOpLo    = 0;
    localparam int condSelLo  = 3;
    localparam int targetLo   = 6;
    localparam int controlsLo = 13;

    // sequencer operations
    localparam logic [seqOpWidth-1:0] seqNext     = 3'd0;
    localparam logic [seqOpWidth-1:0] seqDispatch = 3'd1;
    localparam logic [seqOpWidth-1:0] seqBranch   = 3'd2;
    localparam logic [seqOpWidth-1:0] seqJump     = 3'd3;
    localparam logic [seqOpWidth-1:0] seqWait     = 3'd4;

    // condition select, condAlways makes a branch unconditional
    localparam logic [condSelWidth-1:0] condZero     = 3'd0;
    localparam logic [condSelWidth-1:0] condNegative = 3'd1;
    localparam logic [condSelWidth-1:0] condCarry    = 3'd2;
    localparam logic [condSelWidth-1:0] condAlways   = 3'd3;

    // aluFlags bit order
    localparam int flagZero     = 0;
    localparam int flagNegative = 1;
    localparam int flagCarry    = 2;

    // bit indices within the exported controls
    localparam int ctlMemRead   = 0;
    localparam int ctlIrLoad    = 1;
    localparam int ctlPcInc     = 2;
    localparam int ctlPcLoad    = 3;
    localparam int ctlAccLoad   = 4;
    localparam int ctlLoadFlags = 5;
    localparam int ctlMemWrite  = 6;
    localparam int ctlTrap      = 7;
    localparam int ctlMarLoad   = 8;
    localparam int ctlAluSub    = 9;

    // microstates
    localparam logic [StateWidthDefault-1:0] stFetch       = 7'd0;
    localparam logic [StateWidthDefault-1:0] stFetchWait   = 7'd1;
    localparam logic [StateWidthDefault-1:0] stDecode      = 7'd2;
    localparam logic [StateWidthDefault-1:0] stAddAddr     = 7'd3;
    localparam logic [StateWidthDefault-1:0] stAddRead     = 7'd4;
    localparam logic [StateWidthDefault-1:0] stAddExec     = 7'd5;
    localparam logic [StateWidthDefault-1:0] stSubAddr     = 7'd6;
    localparam logic [StateWidthDefault-1:0] stSubRead     = 7'd7;
    localparam logic [StateWidthDefault-1:0] stSubExec     = 7'd8;
    localparam logic [StateWidthDefault-1:0] stLoadAddr    = 7'd9;
    localparam logic [StateWidthDefault-1:0] stLoadWait    = 7'd10;
    localparam logic [StateWidthDefault-1:0] stLoadExec    = 7'd11;
    localparam logic [StateWidthDefault-1:0] stStoreWrite  = 7'd12;
    localparam logic [StateWidthDefault-1:0] stStoreDone   = 7'd13;
    localparam logic [StateWidthDefault-1:0] stBeqTest     = 7'd14;
    localparam logic [StateWidthDefault-1:0] stBeqSkip     = 7'd15;
    localparam logic [StateWidthDefault-1:0] stBranchTaken = 7'd16;
    localparam logic [StateWidthDefault-1:0] stTrap        = 7'd17;
    localparam logic [StateWidthDefault-1:0] stHalt        = 7'd18;

    // opcodes, every other code is illegal
    localparam logic [opcodeWidth-1:0] opAdd   = 4'h1;
    localparam logic [opcodeWidth-1:0] opSub   = 4'h2;
    localparam logic [opcodeWidth-1:0] opLoad  = 4'h3;
    localparam logic [opcodeWidth-1:0] opStore = 4'h4;
    localparam logic [opcodeWidth-1:0] opBeq   = 4'h5;
    localparam logic [opcodeWidth-1:0] opHalt  = 4'hf;

    // entry state per opcode, illegal codes land in stTrap
    localparam logic [StateWidthDefault-1:0] dispatchEntry [2**opcodeWidth] = '{
        opAdd:   stAddAddr,
        opSub:   stSubAddr,
        opLoad:  stLoadAddr,
        opStore: stStoreWrite,
        opBeq:   stBeqTest,
        opHalt:  stHalt,
        default: stTrap
    };

endpackage

//--- dv/ControlUnit_props.sv
`timescale 1ns/1ps

module ControlUnit_props #(
    parameter int StateWidth = microControlPkg::StateWidthDefault
) (
    input logic                                      clk,
    input logic                                      reset,
    input logic [microControlPkg::opcodeWidth-1:0]   opcode,
    input logic [microControlPkg::flagWidth-1:0]     aluFlags,
    input logic                                      memReady,
    input logic [microControlPkg::controlsWidth-1:0] controls,
    input logic [StateWidth-1:0]                     activeState,
    input logic [StateWidth-1:0]                     state
);
    import microControlPkg::*;

    // worst instruction is about 10 cycles with 3-cycle stalls
    localparam int progressLimit = 16;

    // first failure as the testbench top reads it
    bit          failSeen = 1'b0;
    bit          failIsValue = 1'b0;
    string       failName;
    logic [31:0] failExpected;
    logic [31:0] failActual;
    time         failTime;

    logic [7:0] namedCtl;
    logic       modelZero;
    logic [7:0] sinceFetch;
    logic       execState;

    // named controls with memRead in bit 0
    assign namedCtl = {controls[ctlTrap], controls[ctlMemWrite], controls[ctlLoadFlags],
                       controls[ctlAccLoad], controls[ctlPcLoad], controls[ctlPcInc],
                       controls[ctlIrLoad], controls[ctlMemRead]};

    // add and sub exec are the only flag-loading states
    assign execState = (activeState == stAddExec || activeState == stSubExec);

    // zero flag as add and sub exec leave it
    always_ff @(posedge clk) begin
        if (reset) begin
            modelZero <= 1'b0;
        end else if (execState) begin
            modelZero <= aluFlags[flagZero];
        end
    end

    // cycles since the last fetch
    // halt parks it at 0
    always_ff @(posedge clk) begin
        if (reset || activeState == stFetch || activeState == stHalt) begin
            sinceFetch <= '0;
        end else begin
            sinceFetch <= sinceFetch + 8'd1;
        end
    end

    // entry state per opcode
    function automatic logic [StateWidth-1:0] expectedEntry(input logic [opcodeWidth-1:0] code);
        case (code)
            opAdd: return StateWidth'(stAddAddr);
            opSub: return StateWidth'(stSubAddr);
            opLoad: return StateWidth'(stLoadAddr);
            opStore: return StateWidth'(stStoreWrite);
            opBeq: return StateWidth'(stBeqTest);
            opHalt: return StateWidth'(stHalt);
            default: return StateWidth'(stTrap);
        endcase
    endfunction

    task automatic noteMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (!failSeen) begin
            failIsValue = 1'b1;
            failName = name;
            failExpected = expected;
            failActual = actual;
            failTime = $time;
            failSeen = 1'b1;
        end
        $error("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, expected, actual);
    endtask

    task automatic noteFailure(input string text);
        if (!failSeen) begin
            failIsValue = 1'b0;
            failName = text;
            failTime = $time;
            failSeen = 1'b1;
        end
        $error("%s", text);
    endtask

    // reset and the cycle after it give the fetch word
    resetState: assert property (@(posedge clk) (reset || $past(reset)) |-> activeState == '0)
        else noteMismatch("activeState", 32'd0, 32'($sampled(activeState)));
    resetControls: assert property (@(posedge clk) (reset || $past(reset)) |-> namedCtl == 8'h01)
        else noteMismatch("namedControls", 32'h01, 32'($sampled(namedCtl)));

    // fetch wait stalls on memReady
    fetchHold: assert property (@(posedge clk) disable iff (reset)
        activeState == stFetchWait && !memReady |=> activeState == stFetchWait)
        else noteMismatch("activeState", 32'(stFetchWait), 32'($sampled(activeState)));
    fetchAdvance: assert property (@(posedge clk) disable iff (reset)
        activeState == stFetchWait && memReady |=> activeState == stDecode)
        else noteMismatch("activeState", 32'(stDecode), 32'($sampled(activeState)));

    dispatchTarget: assert property (@(posedge clk) disable iff (reset)
        activeState == stDecode |=> activeState == expectedEntry($past(opcode)))
        else noteMismatch("activeState", 32'(expectedEntry($past(opcode))),
                          32'($sampled(activeState)));

    // illegal opcode path
    trapControl: assert property (@(posedge clk) disable iff (reset)
        activeState == stTrap |-> controls[ctlTrap])
        else noteMismatch("ctlTrap", 32'd1, 32'($sampled(controls[ctlTrap])));
    trapReturn: assert property (@(posedge clk) disable iff (reset)
        activeState == stTrap |=> activeState == stFetch)
        else noteMismatch("activeState", 32'(stFetch), 32'($sampled(activeState)));

    // flag strobe only in the add and sub exec states
    loadFlagsStrobe: assert property (@(posedge clk) disable iff (reset)
        controls[ctlLoadFlags] == execState)
        else noteMismatch("ctlLoadFlags", 32'($sampled(execState)),
                          32'($sampled(controls[ctlLoadFlags])));

    // beq on the last loaded zero flag
    branchTarget: assert property (@(posedge clk) disable iff (reset)
        activeState == stBeqTest |=>
            activeState == ($past(modelZero) ? stBranchTaken : stBeqSkip))
        else noteMismatch("activeState", 32'($past(modelZero) ? stBranchTaken : stBeqSkip),
                          32'($sampled(activeState)));
    branchReturn: assert property (@(posedge clk) disable iff (reset)
        activeState == stBeqSkip || activeState == stBranchTaken |=> activeState == stFetch)
        else noteMismatch("activeState", 32'(stFetch), 32'($sampled(activeState)));

    // sequencer state behind activeState stays inside the table
    stateRange: assert property (@(posedge clk) state <= stHalt)
        else noteFailure("microstate register went above the last microstate");
    haltHold: assert property (@(posedge clk) disable iff (reset)
        activeState == stHalt |=> activeState == stHalt)
        else noteMismatch("activeState", 32'(stHalt), 32'($sampled(activeState)));
    progress: assert property (@(posedge clk) disable iff (reset) sinceFetch < progressLimit)
        else noteFailure("instruction did not return to fetch within the cycle bound");

endmodule

bind ControlUnit ControlUnit_props #(
    .StateWidth(StateWidth)
) i_ControlUnit_props (
    .clk(clk),
    .reset(reset),
    .opcode(opcode),
    .aluFlags(aluFlags),
    .memReady(memReady),
    .controls(controls),
    .activeState(activeState),
    .state(state)
);

//--- dv/ControlUnit_tb.sv
`timescale 1ns/1ps

module ControlUnit_tb;
    import microControlPkg::*;

    localparam int numInstr   = 60;
    localparam int cycleLimit = 40 * numInstr + 20;

    logic                         clk;
    logic                         reset;
    logic [opcodeWidth-1:0]       opcode;
    logic [flagWidth-1:0]         aluFlags;
    logic                         memReady;
    logic [controlsWidth-1:0]     controls;
    logic [StateWidthDefault-1:0] activeState;
    int                           cycleCount = 0;

    ControlUnit #(
        .StateWidth(StateWidthDefault),
        .WordWidth(WordWidthDefault)
    ) i_ControlUnit (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .aluFlags(aluFlags),
        .memReady(memReady),
        .controls(controls),
        .activeState(activeState)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("TIMEOUT: run went past %0d cycles without finishing", cycleLimit);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic reportAssertionFailure();
        if (i_ControlUnit.i_ControlUnit_props.failIsValue) begin
            $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
                     i_ControlUnit.i_ControlUnit_props.failTime,
                     i_ControlUnit.i_ControlUnit_props.failName,
                     i_ControlUnit.i_ControlUnit_props.failExpected,
                     i_ControlUnit.i_ControlUnit_props.failActual);
        end else begin
            $display("FAILURE at time %0t: %s",
                     i_ControlUnit.i_ControlUnit_props.failTime,
                     i_ControlUnit.i_ControlUnit_props.failName);
        end
        $display("TESTBENCH FAILED");
        $fatal(1, "assertion failure");
    endtask

    // first failed assertion ends the run
    always @(negedge clk) begin
        if (i_ControlUnit.i_ControlUnit_props.failSeen) begin
            reportAssertionFailure();
        end
    end

    // states that sample memReady
    function automatic bit isWaitState(input logic [StateWidthDefault-1:0] st);
        return st == stFetchWait || st == stLoadWait || st == stStoreWrite;
    endfunction

    function automatic logic [opcodeWidth-1:0] pickOpcode(input int index);
        logic [opcodeWidth-1:0] code;
        // halt midway and at the end, the rest mostly legal
        if (index == numInstr / 2 || index == numInstr - 1) begin
            code = opHalt;
        end else begin
            case ($urandom_range(7, 0))
                0, 1: code = opAdd;
                2: code = opSub;
                3: code = opLoad;
                4: code = opStore;
                5, 6: code = opBeq;
                default: code = 4'($urandom_range(15, 0));
            endcase
        end
        return code;
    endfunction

    task automatic applyReset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // one instruction from fetch back to fetch, or into halt
    task automatic runInstruction(input logic [opcodeWidth-1:0] code);
        logic [StateWidthDefault-1:0] prevState;
        int                           waitLeft;
        prevState = '1;
        waitLeft = 0;
        opcode = code;
        do begin
            if (isWaitState(activeState)) begin
                // new stall length on entry to a wait state
                if (activeState != prevState) begin
                    waitLeft = $urandom_range(3, 0);
                end
                memReady = (waitLeft == 0);
                if (waitLeft > 0) begin
                    waitLeft = waitLeft - 1;
                end
            end else begin
                memReady = 1'($urandom_range(1, 0));
            end
            aluFlags = 3'($urandom_range(7, 0));
            prevState = activeState;
            @(negedge clk);
        end while (activeState != stFetch && activeState != stHalt);
        if (activeState == stHalt) begin
            // park in halt, only reset leaves it
            repeat (5) @(negedge clk);
            applyReset();
        end
    endtask

    initial begin
        void'($urandom(32'h28450a2e));
        reset = 1'b1;
        opcode = '0;
        aluFlags = '0;
        memReady = 1'b0;
        applyReset();
        for (int i = 0; i < numInstr; i++) begin
            runInstruction(pickOpcode(i));
        end
        @(negedge clk);
        if (i_ControlUnit.i_ControlUnit_props.failSeen) begin
            reportAssertionFailure();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- microControl.f
common/microControlPkg.sv
source/ConditionCodes.sv
microcode/MicroSequencer.sv
microcode/Microstore.sv
source/ControlUnit.sv
dv/ControlUnit_props.sv
dv/ControlUnit_tb.sv

//--- microcode/MicroSequencer.sv
`timescale 1ns/1ps

module MicroSequencer #(
    parameter int StateWidth = microControlPkg::StateWidthDefault
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [microControlPkg::seqOpWidth-1:0]  seqOp,
    input  logic [StateWidth-1:0]                  target,
    input  logic [microControlPkg::opcodeWidth-1:0] opcode,
    input  logic                                   condTrue,
    input  logic                                   memReady,
    output logic [StateWidth-1:0]                  currentState
);
    import microControlPkg::*;

    logic [StateWidth-1:0] nextState;
    logic [StateWidth-1:0] stateInc;
    logic [StateWidth-1:0] dispatchState;

    // sequential successor
    assign stateInc = currentState + 1'b1;

    // opcode lookup, illegal codes already map to stTrap in the table
    assign dispatchState = StateWidth'(dispatchEntry[opcode]);

    // next-state select by the word's seqOp field
    always_comb begin
        case (seqOp)
            seqNext: begin
                nextState = stateInc;
            end
            seqDispatch: begin
                nextState = dispatchState;
            end
            seqBranch: begin
                // condTrue comes from flags latched in earlier states
                if (condTrue) begin
                    nextState = target;
                end else begin
                    nextState = stateInc;
                end
            end
            seqJump: begin
                nextState = target;
            end
            seqWait: begin
                // stall here until memory is ready
                if (memReady) begin
                    nextState = stateInc;
                end else begin
                    nextState = currentState;
                end
            end
            default: begin
                // undefined op, restart at fetch
                nextState = StateWidth'(stFetch);
            end
        endcase
    end

    // microstate register
    always_ff @(posedge clk) begin
        if (reset) begin
            currentState <= StateWidth'(stFetch);
        end else begin
            currentState <= nextState;
        end
    end

endmodule

//--- microcode/Microstore.sv
`timescale 1ns/1ps

module Microstore #(
    parameter int StateWidth = microControlPkg::StateWidthDefault,
    parameter int WordWidth  = microControlPkg::WordWidthDefault
) (
    input  logic                  reset,
    input  logic [StateWidth-1:0] currentState,
    output logic [WordWidth-1:0]  currentStateSignals,
    output logic [StateWidth-1:0] activeState
);
    import microControlPkg::*;

    // word fields, packed below as {controls, target, condSel, seqOp}
    logic [controlsWidth-1:0] ctl;
    logic [StateWidth-1:0]    tgt;
    logic [condSelWidth-1:0]  cond;
    logic [seqOpWidth-1:0]    op;

    always_comb begin
        // defaults give the fetch word minus memRead
        ctl = '0;
        tgt = StateWidth'(stFetch);
        cond = condAlways;
        op = seqNext;
        activeState = currentState;
        if (reset) begin
            // forced fetch word during reset
            ctl[ctlMemRead] = 1'b1;
            activeState = '0;
        end else begin
            case (currentState)
                // instruction fetch and decode
                stFetch: ctl[ctlMemRead] = 1'b1;
                stFetchWait: begin
                    ctl[ctlMemRead] = 1'b1;
                    op = seqWait;
                end
                stDecode: begin
                    ctl[ctlIrLoad] = 1'b1;
                    ctl[ctlPcInc] = 1'b1;
                    op = seqDispatch;
                end
                // add and sub share one pattern, only the alu select differs
                stAddAddr, stSubAddr: ctl[ctlMarLoad] = 1'b1;
                stAddRead, stSubRead: ctl[ctlMemRead] = 1'b1;
                stAddExec, stSubExec: begin
                    ctl[ctlAccLoad] = 1'b1;
                    ctl[ctlLoadFlags] = 1'b1;
                    ctl[ctlAluSub] = (currentState == stSubExec);
                    op = seqJump;
                end
                // load waits on the memory
                stLoadAddr: ctl[ctlMarLoad] = 1'b1;
                stLoadWait: begin
                    ctl[ctlMemRead] = 1'b1;
                    op = seqWait;
                end
                stLoadExec: begin
                    ctl[ctlAccLoad] = 1'b1;
                    op = seqJump;
                end
                stStoreWrite: begin
                    ctl[ctlMemWrite] = 1'b1;
                    op = seqWait;
                end
                stStoreDone: op = seqJump;
                // beq: taken goes to stBranchTaken, else falls into stBeqSkip
                stBeqTest: begin
                    cond = condZero;
                    tgt = StateWidth'(stBranchTaken);
                    op = seqBranch;
                end
                stBeqSkip: op = seqJump;
                stBranchTaken: begin
                    ctl[ctlPcLoad] = 1'b1;
                    op = seqJump;
                end
                stTrap: begin
                    ctl[ctlTrap] = 1'b1;
                    op = seqJump;
                end
                // halt spins on itself until reset
                stHalt: begin
                    tgt = StateWidth'(stHalt);
                    op = seqJump;
                end
                // unused states fall back to fetch
                default: begin
                    ctl[ctlMemRead] = 1'b1;
                    activeState = '0;
                end
            endcase
        end
    end

    assign currentStateSignals = {ctl, tgt, cond, op};

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# build and run the ControlUnit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir="obj_dir"
logFile="sim.log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ControlUnit_tb -f microControl.f \
    --Mdir "$buildDir" -o ControlUnit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# raise the error limit so the testbench reports the first assertion failure itself
"./$buildDir/ControlUnit_sim" +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TESTBENCH FAILED" "$logFile"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

echo "simulation finished without failure"
exit 0

//--- source/ConditionCodes.sv
`timescale 1ns/1ps

module ConditionCodes (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    loadFlags,
    input  logic [microControlPkg::flagWidth-1:0]    aluFlags,
    input  logic [microControlPkg::condSelWidth-1:0] condSel,
    output logic                                    condTrue
);
    import microControlPkg::*;

    // zero, negative, carry as last captured
    logic [flagWidth-1:0] flags;

    // capture on the edge that ends a loadFlags state
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (loadFlags) begin
            flags <= aluFlags;
        end
    end

    // tested condition for the sequencer
    always_comb begin
        case (condSel)
            condZero: begin
                condTrue = flags[flagZero];
            end
            condNegative: begin
                condTrue = flags[flagNegative];
            end
            condCarry: begin
                condTrue = flags[flagCarry];
            end
            condAlways: begin
                condTrue = 1'b1;
            end
            default: begin
                // unused selects never branch
                condTrue = 1'b0;
            end
        endcase
    end

endmodule

//--- source/ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit #(
    parameter int StateWidth = microControlPkg::StateWidthDefault,
    parameter int WordWidth  = microControlPkg::WordWidthDefault
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [microControlPkg::opcodeWidth-1:0]   opcode,
    input  logic [microControlPkg::flagWidth-1:0]     aluFlags,
    input  logic                                      memReady,
    output logic [microControlPkg::controlsWidth-1:0] controls,
    output logic [StateWidth-1:0]                     activeState
);
    import microControlPkg::*;

    logic [StateWidth-1:0]   state;
    logic [WordWidth-1:0]    word;
    logic [seqOpWidth-1:0]   seqOp;
    logic [condSelWidth-1:0] condSel;
    logic [StateWidth-1:0]   target;
    logic                    condTrue;

    // control word fields
    assign seqOp    = word[seqOpLo +: seqOpWidth];
    assign condSel  = word[condSelLo +: condSelWidth];
    assign target   = word[targetLo +: StateWidth];
    assign controls = word[controlsLo +: controlsWidth];

    MicroSequencer #(
        .StateWidth(StateWidth)
    ) i_MicroSequencer (
        .clk(clk),
        .reset(reset),
        .seqOp(seqOp),
        .target(target),
        .opcode(opcode),
        .condTrue(condTrue),
        .memReady(memReady),
        .currentState(state)
    );

    Microstore #(
        .StateWidth(StateWidth),
        .WordWidth(WordWidth)
    ) i_Microstore (
        .reset(reset),
        .currentState(state),
        .currentStateSignals(word),
        .activeState(activeState)
    );

    // flag load strobe comes straight from the controls field
    ConditionCodes i_ConditionCodes (
        .clk(clk),
        .reset(reset),
        .loadFlags(controls[ctlLoadFlags]),
        .aluFlags(aluFlags),
        .condSel(condSel),
        .condTrue(condTrue)
    );

endmodule
